// ==== compile.f ====
rv_pkg.sv
rv_core_ctrl.sv
rv_fetch_decode.sv
rv_regfile.sv
rv_exec.sv
rv_lsu.sv
rv_core_top.sv
tb_clk_gen.sv
tb_core.sv

// ==== rv_core_ctrl.sv ====
/* core control, sweep and program counters */
`timescale 1ns/1ps

module rv_core_ctrl
#(
    parameter rv_pkg::word_t RESET_PC = '0
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             hlt,
    input  logic             jump_taken,       // taken jal/jalr/branch in execute
    input  rv_pkg::word_t    jump_target,
    input  logic             is_wb,            // decoded instruction writes rd
    output rv_pkg::word_t    pc,               // address of the executing instruction
    output rv_pkg::word_t    nxpc,             // address of the word on idata
    output rv_pkg::word_t    iaddr,
    output logic             flush,
    output logic             ex_valid,
    output logic             rf_we,
    output logic             sweep_active,
    output logic             idle,
    output rv_pkg::reg_idx_t sweep_idx
);
    import rv_pkg::*;

    word_t fetch_next;                         // sequential or redirected fetch

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sweep_active <= 1'b1;
            sweep_idx    <= reg_idx_t'(NUM_REGS - 1);   // count down to x0
        end
        else if (!hlt && sweep_active)
        begin
            if (sweep_idx == '0)
                sweep_active <= 1'b0;          // last register written
            else
                sweep_idx <= sweep_idx - 1'b1;
        end
    end

    // one dead slot after the sweep and after every taken transfer
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            flush <= 1'b1;
        else if (!hlt)
            flush <= sweep_active | jump_taken;
    end

    assign fetch_next = jump_taken ? jump_target : nxpc + 32'd4;
    assign iaddr      = sweep_active ? RESET_PC :
                        hlt          ? nxpc     :  // re-fetch same word, memory output holds
                                       fetch_next;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            nxpc <= RESET_PC;
            pc   <= RESET_PC;
        end
        else if (!hlt)
        begin
            nxpc <= iaddr;                     // word arrives with this address
            pc   <= nxpc;                      // follows the instruction into execute
        end
    end

    // halt also blocks execution so no strobe repeats while frozen
    assign ex_valid = !flush && !sweep_active && !hlt;
    assign rf_we    = ex_valid && is_wb;
    assign idle     = flush | sweep_active;

    // a flushed slot never carries a transfer, so flushes cannot chain
    a_flush_single: assert property (@(posedge CLK) disable iff (!rst_n)
        (flush && !sweep_active && !hlt) |=> !flush);

endmodule

// ==== rv_core_top.sv ====
/* rv32i two-stage core */
`timescale 1ns/1ps

module rv_core_top
#(
    parameter rv_pkg::word_t RESET_PC = '0,
    parameter rv_pkg::word_t RESET_SP = 32'd4096
)
(
    input  logic          CLK,
    input  logic          rst_n,
    input  rv_pkg::word_t idata,               // instruction bus
    output rv_pkg::word_t iaddr,
    input  rv_pkg::word_t datai,               // data bus
    output rv_pkg::word_t datao,
    output rv_pkg::word_t daddr,
    output rv_pkg::be_t   be,
    output logic          rd,
    output logic          wr,
    input  logic          hlt,
    output logic          idle
);
    import rv_pkg::*;

    logic     is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic     is_load, is_store, is_imm, is_reg, is_wb;
    reg_idx_t rs1, rs2, rd_idx, sweep_idx;
    funct3_t  funct3;
    logic     alt;
    word_t    simm, uimm, rs1_val, rs2_val, rd_data, load_data;
    word_t    pc, nxpc, jump_target;
    logic     jump_taken, ex_valid, rf_we, sweep_active;

    rv_core_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
        .CLK, .rst_n, .hlt, .jump_taken, .jump_target, .is_wb,
        .pc, .nxpc, .iaddr, .flush(), .ex_valid, .rf_we,
        .sweep_active, .idle, .sweep_idx
    );

    rv_fetch_decode u_decode (
        .CLK, .rst_n, .hlt, .idata,
        .is_lui, .is_auipc, .is_jal, .is_jalr, .is_branch,
        .is_load, .is_store, .is_imm, .is_reg, .is_wb,
        .rs1, .rs2, .rd(rd_idx), .funct3, .alt, .simm, .uimm
    );

    rv_regfile #(.RESET_SP(RESET_SP)) u_regfile (
        .CLK, .rst_n, .hlt, .rs1, .rs2, .rd(rd_idx), .rd_data, .rf_we,
        .sweep_active, .sweep_idx, .rs1_val, .rs2_val
    );

    rv_exec u_exec (
        .is_lui, .is_auipc, .is_jal, .is_jalr, .is_branch,
        .is_load, .is_imm, .is_reg, .ex_valid, .funct3, .alt,
        .simm, .uimm, .rs1_val, .rs2_val, .pc, .nxpc, .daddr, .load_data,
        .rd_data, .jump_taken, .jump_target
    );

    rv_lsu u_lsu (
        .CLK, .rst_n, .is_load, .is_store, .ex_valid, .funct3,
        .simm, .rs1_val, .rs2_val, .datai,
        .daddr, .datao, .be, .rd, .wr, .load_data
    );

endmodule

// ==== rv_exec.sv ====
/* alu, branch and writeback select */
`timescale 1ns/1ps

module rv_exec
(
    input  logic            is_lui,
    input  logic            is_auipc,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic            is_branch,
    input  logic            is_load,
    input  logic            is_imm,
    input  logic            is_reg,
    input  logic            ex_valid,          // not flushed, not sweeping, not halted
    input  rv_pkg::funct3_t funct3,
    input  logic            alt,
    input  rv_pkg::word_t   simm,
    input  rv_pkg::word_t   uimm,
    input  rv_pkg::word_t   rs1_val,
    input  rv_pkg::word_t   rs2_val,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   nxpc,              // link value, pc+4
    input  rv_pkg::word_t   daddr,             // rs1+simm from the lsu
    input  rv_pkg::word_t   load_data,
    output rv_pkg::word_t   rd_data,
    output logic            jump_taken,
    output rv_pkg::word_t   jump_target
);
    import rv_pkg::*;

    word_t      op2;
    word_t      alu;
    word_t      pc_simm;                       // auipc result and pc-relative target
    logic [4:0] shamt;
    logic       br_cond;

    assign op2     = is_imm ? simm : rs2_val;
    assign shamt   = is_imm ? uimm[4:0] : rs2_val[4:0];
    assign pc_simm = pc + simm;

    always_comb
    begin
        alu = '0;
        case (funct3)
            F3_ADD:  alu = (is_reg && alt) ? rs1_val - op2 : rs1_val + op2;  // no subi
            F3_SLL:  alu = rs1_val << shamt;
            F3_SLT:  alu = word_t'($signed(rs1_val) < $signed(op2));
            F3_SLTU: alu = word_t'(rs1_val < op2);  // sltiu compares sign-extended imm
            F3_XOR:  alu = rs1_val ^ op2;
            F3_SR:   alu = alt ? word_t'($signed(rs1_val) >>> shamt) : rs1_val >> shamt;
            F3_OR:   alu = rs1_val | op2;
            F3_AND:  alu = rs1_val & op2;
        endcase
    end

    always_comb
    begin
        case (funct3)
            F3_BEQ:  br_cond = rs1_val == rs2_val;
            F3_BNE:  br_cond = rs1_val != rs2_val;
            F3_BLT:  br_cond = $signed(rs1_val) <  $signed(rs2_val);
            F3_BGE:  br_cond = $signed(rs1_val) >= $signed(rs2_val);
            F3_BLTU: br_cond = rs1_val <  rs2_val;
            F3_BGEU: br_cond = rs1_val >= rs2_val;
            default: br_cond = 1'b0;           // reserved encodings never branch
        endcase
    end

    assign jump_taken  = ex_valid && (is_jal || is_jalr || (is_branch && br_cond));
    assign jump_target = is_jalr ? {daddr[XLEN-1:1], 1'b0} : pc_simm;  // jalr drops bit 0

    assign rd_data = is_auipc          ? pc_simm   :
                     is_jal || is_jalr ? nxpc      :
                     is_lui            ? simm      :
                     is_load           ? load_data :
                                         alu;

endmodule

// ==== rv_fetch_decode.sv ====
/* instruction register and decode */
`timescale 1ns/1ps

module rv_fetch_decode
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             hlt,
    input  rv_pkg::word_t    idata,            // word from synchronous instruction memory
    output logic             is_lui,
    output logic             is_auipc,
    output logic             is_jal,
    output logic             is_jalr,
    output logic             is_branch,
    output logic             is_load,
    output logic             is_store,
    output logic             is_imm,
    output logic             is_reg,
    output logic             is_wb,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::funct3_t  funct3,
    output logic             alt,              // sub/sra select
    output rv_pkg::word_t    simm,             // sign extended immediate
    output rv_pkg::word_t    uimm              // zero extended immediate
);
    import rv_pkg::*;

    opcode_t op;
    word_t   ir;
    word_t   simm_nx;
    word_t   uimm_nx;

    assign op = opcode_t'(idata[6:0]);

    // immediate layout per format
    always_comb
    begin
        case (op)
            OP_STORE:                          // s-type
            begin
                simm_nx = {{(XLEN-12){idata[31]}}, idata[31:25], idata[11:7]};
                uimm_nx = {{(XLEN-12){1'b0}}, idata[31:25], idata[11:7]};
            end
            OP_BRANCH:                         // b-type, bit 0 always zero
            begin
                simm_nx = {{(XLEN-13){idata[31]}}, idata[31], idata[7],
                           idata[30:25], idata[11:8], 1'b0};
                uimm_nx = {{(XLEN-13){1'b0}}, idata[31], idata[7],
                           idata[30:25], idata[11:8], 1'b0};
            end
            OP_JAL:                            // j-type
            begin
                simm_nx = {{(XLEN-21){idata[31]}}, idata[31], idata[19:12],
                           idata[20], idata[30:21], 1'b0};
                uimm_nx = {{(XLEN-21){1'b0}}, idata[31], idata[19:12],
                           idata[20], idata[30:21], 1'b0};
            end
            OP_LUI, OP_AUIPC:                  // u-type, no extension needed
            begin
                simm_nx = {idata[31:12], 12'h000};
                uimm_nx = {idata[31:12], 12'h000};
            end
            default:                           // i-type: jalr, loads, alu imm
            begin
                simm_nx = {{(XLEN-12){idata[31]}}, idata[31:20]};
                uimm_nx = {{(XLEN-12){1'b0}}, idata[31:20]};
            end
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ir        <= '0;
            is_lui    <= 1'b0;
            is_auipc  <= 1'b0;
            is_jal    <= 1'b0;
            is_jalr   <= 1'b0;
            is_branch <= 1'b0;
            is_load   <= 1'b0;
            is_store  <= 1'b0;
            is_imm    <= 1'b0;
            is_reg    <= 1'b0;
            simm      <= '0;
            uimm      <= '0;
        end
        else if (!hlt)                         // whole stage freezes on halt
        begin
            ir        <= idata;
            is_lui    <= op == OP_LUI;
            is_auipc  <= op == OP_AUIPC;
            is_jal    <= op == OP_JAL;
            is_jalr   <= op == OP_JALR;
            is_branch <= op == OP_BRANCH;
            is_load   <= op == OP_LOAD;
            is_store  <= op == OP_STORE;
            is_imm    <= op == OP_IMM;
            is_reg    <= op == OP_REG;
            simm      <= simm_nx;
            uimm      <= uimm_nx;
        end
    end

    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign alt    = ir[30];
    assign is_wb  = is_lui | is_auipc | is_jal | is_jalr | is_load | is_imm | is_reg;

endmodule

// ==== rv_lsu.sv ====
/* load/store lane unit */
`timescale 1ns/1ps

module rv_lsu
(
    input  logic            CLK,
    input  logic            rst_n,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            ex_valid,
    input  rv_pkg::funct3_t funct3,
    input  rv_pkg::word_t   simm,
    input  rv_pkg::word_t   rs1_val,
    input  rv_pkg::word_t   rs2_val,
    input  rv_pkg::word_t   datai,             // combinational read data
    output rv_pkg::word_t   daddr,
    output rv_pkg::word_t   datao,
    output rv_pkg::be_t     be,
    output logic            rd,
    output logic            wr,
    output rv_pkg::word_t   load_data
);
    import rv_pkg::*;

    logic [1:0] lane;
    be_t        be_raw;
    word_t      lane_data;                     // addressed lane moved to bit 0

    assign daddr = rs1_val + simm;             // also the jalr target
    assign lane  = daddr[1:0];
    assign rd    = ex_valid && is_load;
    assign wr    = ex_valid && is_store;

    always_comb
    begin
        case (funct3)
            F3_B, F3_BU:
            begin
                be_raw = be_t'(4'b0001 << lane);
                datao  = word_t'(rs2_val[7:0]) << {lane, 3'b000};
            end
            F3_H, F3_HU:                       // halves assumed aligned
            begin
                be_raw = lane[1] ? 4'b1100 : 4'b0011;
                datao  = word_t'(rs2_val[15:0]) << {lane[1], 4'b0000};
            end
            default:
            begin
                be_raw = 4'b1111;
                datao  = rs2_val;
            end
        endcase
    end

    assign be        = (rd || wr) ? be_raw : '0;
    assign lane_data = datai >> {lane, 3'b000};

    always_comb
    begin
        case (funct3)
            F3_B:    load_data = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
            F3_BU:   load_data = {{(XLEN-8){1'b0}}, lane_data[7:0]};
            F3_H:    load_data = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
            F3_HU:   load_data = {{(XLEN-16){1'b0}}, lane_data[15:0]};
            default: load_data = datai;        // lw
        endcase
    end

    // decode raises one class flag at most, so the strobes stay exclusive
    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(rd && wr));

endmodule

// ==== rv_pkg.sv ====
/* rv32i core definitions */
package rv_pkg;

    localparam int XLEN     = 32;                  // data and address width
    localparam int NUM_REGS = 32;                  // full rv32i register set

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [6:0]                  opcode_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [3:0]                  be_t;     // one bit per byte lane

    localparam reg_idx_t SP_IDX = 5'd2;            // x2, loaded by the reset sweep

    // major opcodes, bits [6:0] of the instruction
    localparam opcode_t OP_LUI    = 7'b0110111;    // lui   rd,imm
    localparam opcode_t OP_AUIPC  = 7'b0010111;    // auipc rd,imm
    localparam opcode_t OP_JAL    = 7'b1101111;    // jal   rd,offs
    localparam opcode_t OP_JALR   = 7'b1100111;    // jalr  rd,rs1,imm
    localparam opcode_t OP_BRANCH = 7'b1100011;    // bxx   rs1,rs2,offs
    localparam opcode_t OP_LOAD   = 7'b0000011;    // lx    rd,imm(rs1)
    localparam opcode_t OP_STORE  = 7'b0100011;    // sx    rs2,imm(rs1)
    localparam opcode_t OP_IMM    = 7'b0010011;    // xxxi  rd,rs1,imm
    localparam opcode_t OP_REG    = 7'b0110011;    // xxx   rd,rs1,rs2

    // alu group
    localparam funct3_t F3_ADD  = 3'd0;            // add/sub, sub via bit 30
    localparam funct3_t F3_SLL  = 3'd1;
    localparam funct3_t F3_SLT  = 3'd2;
    localparam funct3_t F3_SLTU = 3'd3;
    localparam funct3_t F3_XOR  = 3'd4;
    localparam funct3_t F3_SR   = 3'd5;            // srl/sra, sra via bit 30
    localparam funct3_t F3_OR   = 3'd6;
    localparam funct3_t F3_AND  = 3'd7;

    // branch group
    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    // load/store width, bit 2 marks zero extension
    localparam funct3_t F3_B    = 3'd0;
    localparam funct3_t F3_H    = 3'd1;
    localparam funct3_t F3_W    = 3'd2;
    localparam funct3_t F3_BU   = 3'd4;
    localparam funct3_t F3_HU   = 3'd5;

endpackage

// ==== rv_regfile.sv ====
/* dual copy register file */
`timescale 1ns/1ps

module rv_regfile
#(
    parameter rv_pkg::word_t RESET_SP = 32'd4096
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             hlt,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    rd_data,
    input  logic             rf_we,
    input  logic             sweep_active,
    input  rv_pkg::reg_idx_t sweep_idx,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val
);
    import rv_pkg::*;

    word_t regs_a [NUM_REGS];                  // serves read port 1
    word_t regs_b [NUM_REGS];                  // serves read port 2

    always_ff @(posedge CLK)
    begin
        if (sweep_active && !hlt)
        begin
            regs_a[sweep_idx] <= (sweep_idx == SP_IDX) ? RESET_SP : '0;
            regs_b[sweep_idx] <= (sweep_idx == SP_IDX) ? RESET_SP : '0;
        end
        else if (rf_we && rd != '0)            // x0 keeps its swept zero
        begin
            regs_a[rd] <= rd_data;
            regs_b[rd] <= rd_data;
        end
    end

    assign rs1_val = regs_a[rs1];
    assign rs2_val = regs_b[rs2];

    // x0 holds zero only because the sweep cleared it and writes skip it
    a_x0_zero: assert property (@(posedge CLK) disable iff (!rst_n)
        !sweep_active |-> ((rs1 != '0 || rs1_val == '0) && (rs2 != '0 || rs2_val == '0)));

endmodule

// ==== tb_clk_gen.sv ====
/* testbench clock source */
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int PERIOD_NS = 40
)
(
    output logic CLK
);
    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;   // 50% duty
    end

endmodule

// ==== tb_core.sv ====
/* rv32i core testbench */
`timescale 1ns/1ps

module tb_core;
    import rv_pkg::*;

    localparam word_t       RESET_PC = 32'h0000_0000;
    localparam word_t       RESET_SP = 32'h0000_1000;
    localparam int          RES_BASE = 'h400;          // result words, reached from x0
    localparam int          NSLOT    = 256;
    localparam logic [11:0] BAD_ADDR = 12'h7FC;        // last slot, never expected
    localparam int          LD_BASE  = 'h200;          // preloaded load words
    localparam int          RST_CYC  = 8;
    localparam word_t       LD_WORDS [2] = '{32'h8A7F_F183, 32'h7F12_6A34};

    logic       CLK, rst_n, hlt, rd, wr, idle, in_area;
    word_t      idata, iaddr, datai, datao, daddr;
    be_t        be;
    logic [7:0] slot_idx;
    word_t      imem [1024];
    word_t      dmem [512];
    word_t      exp_data [NSLOT];
    be_t        exp_be [NSLOT];
    string      exp_name [NSLOT];
    bit         exp_used [NSLOT];
    bit         seen [NSLOT];
    int         prog_len, exp_cnt, seen_cnt, sweep_cyc;

    tb_clk_gen #(.PERIOD_NS(40)) clk_src (.CLK);

    rv_core_top #(.RESET_PC(RESET_PC), .RESET_SP(RESET_SP)) dut0 (
        .CLK, .rst_n, .idata, .iaddr, .datai, .datao, .daddr, .be,
        .rd, .wr, .hlt, .idle
    );

    always @(posedge CLK)
        idata <= imem[iaddr[11:2]];                    // one cycle read latency

    assign datai    = rd ? dmem[daddr[10:2]] : '0;     // combinational read, only with rd
    assign in_area  = daddr[31:10] == 22'd1;           // 0x400..0x7ff
    assign slot_idx = daddr[9:2];

    always @(posedge CLK)
    begin
        if (wr)
            for (int i = 0; i < 4; i++)
                if (be[i])
                    dmem[daddr[10:2]][8*i +: 8] <= datao[8*i +: 8];
        if (rst_n && wr && in_area && exp_used[slot_idx] && !seen[slot_idx])
        begin
            seen[slot_idx] <= 1'b1;
            seen_cnt       <= seen_cnt + 1;
        end
    end

    // cycles since reset release, stops counting after the sweep
    always @(posedge CLK)
    begin
        if (!rst_n)
            sweep_cyc <= 0;
        else if (sweep_cyc < NUM_REGS)
            sweep_cyc <= sweep_cyc + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    a_reset_quiet: assert property (@(posedge CLK) !rst_n |-> !rd && !wr && be == '0)
        else fail_run("data strobe active during reset");
    a_sweep_idle: assert property (@(posedge CLK) disable iff (!rst_n)
        sweep_cyc < NUM_REGS |-> idle && !rd && !wr && be == '0)
        else fail_run("core not idle or data strobe active during the register sweep");
    a_idle_quiet: assert property (@(posedge CLK) disable iff (!rst_n) idle |-> !rd && !wr)
        else fail_run("data strobe active while idle");
    a_halt_iaddr: assert property (@(posedge CLK) disable iff (!rst_n)
        hlt && $past(hlt) |-> $stable(iaddr))
        else fail_run("iaddr moved while halted");
    a_halt_nowr: assert property (@(posedge CLK) disable iff (!rst_n) hlt |-> !wr)
        else fail_run("store issued while halted");
    a_store_addr: assert property (@(posedge CLK) disable iff (!rst_n)
        wr |-> in_area && exp_used[slot_idx])
        else fail_run($sformatf("store to unexpected address %h", $sampled(daddr)));
    a_store_data: assert property (@(posedge CLK) disable iff (!rst_n)
        wr && in_area && exp_used[slot_idx] |-> datao == exp_data[slot_idx])
        else fail_run($sformatf("FAILED %s expected %h actual %h",
                      exp_name[$sampled(slot_idx)], exp_data[$sampled(slot_idx)],
                      $sampled(datao)));
    a_store_be: assert property (@(posedge CLK) disable iff (!rst_n)
        wr && in_area && exp_used[slot_idx] |-> be == exp_be[slot_idx])
        else fail_run($sformatf("FAILED %s be expected %h actual %h",
                      exp_name[$sampled(slot_idx)], exp_be[$sampled(slot_idx)],
                      $sampled(be)));

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input funct3_t f3, input reg_idx_t rdst, input opcode_t op);
        return {imm, rs1, f3, rdst, op};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_imm(input reg_idx_t r, input word_t v);
        word_t hi;
        hi = v + 32'h800;                              // addi sign extends the low part
        emit({hi[31:12], r, OP_LUI});
        emit(enc_i(v[11:0], r, F3_ADD, r, OP_IMM));
    endtask

    // sw/sh/sb from x0 into the next free result slot
    task automatic store_check(input string name, input funct3_t f3, input reg_idx_t r,
                               input word_t value, input int off);
        logic [11:0] addr;
        addr = 12'(RES_BASE + 4*exp_cnt + off);
        exp_used[exp_cnt] = 1'b1;
        exp_name[exp_cnt] = name;
        case (f3)
            F3_B:
            begin
                exp_data[exp_cnt] = word_t'(value[7:0]) << (8*off);
                exp_be[exp_cnt]   = be_t'(4'b0001 << off);
            end
            F3_H:
            begin
                exp_data[exp_cnt] = word_t'(value[15:0]) << (8*off);
                exp_be[exp_cnt]   = be_t'(4'b0011 << off);
            end
            default:
            begin
                exp_data[exp_cnt] = value;
                exp_be[exp_cnt]   = 4'hF;
            end
        endcase
        emit({addr[11:5], r, 5'd0, f3, addr[4:0], OP_STORE});
        exp_cnt++;
    endtask

    task automatic skipped_store();
        emit({BAD_ADDR[11:5], 5'd5, 5'd0, F3_W, BAD_ADDR[4:0], OP_STORE});  // sits in flushed slot
    endtask

    task automatic alu_case(input string name, input bit reg_form, input funct3_t f3,
                            input bit sub_sra, input word_t a, input word_t b,
                            input word_t expected);
        load_imm(5'd5, a);
        if (reg_form)
        begin
            load_imm(5'd6, b);
            emit({1'b0, sub_sra, 5'd0, 5'd6, 5'd5, f3, 5'd7, OP_REG});
        end
        else
            emit(enc_i(b[11:0], 5'd5, f3, 5'd7, OP_IMM));
        store_check(name, F3_W, 5'd7, expected, 0);
    endtask

    task automatic load_case(input funct3_t f3, input int j, input int off);
        word_t w;
        word_t v;
        string tag;
        w = LD_WORDS[j] >> (8*off);
        case (f3)
            F3_B:
            begin
                v   = {{24{w[7]}}, w[7:0]};
                tag = "lb";
            end
            F3_BU:
            begin
                v   = {24'd0, w[7:0]};
                tag = "lbu";
            end
            F3_H:
            begin
                v   = {{16{w[15]}}, w[15:0]};
                tag = "lh";
            end
            F3_HU:
            begin
                v   = {16'd0, w[15:0]};
                tag = "lhu";
            end
            default:
            begin
                v   = w;
                tag = "lw";
            end
        endcase
        emit(enc_i(12'(LD_BASE + 4*j + off), 5'd0, f3, 5'd9, OP_LOAD));
        store_check($sformatf("%s word %0d off %0d", tag, j, off), F3_W, 5'd9, v, 0);
    endtask

    task automatic branch_case(input string name, input funct3_t f3, input word_t a,
                               input word_t b, input bit taken);
        logic [12:0] boff;
        boff = 13'd8;                                  // skip one instruction
        load_imm(5'd5, a);
        load_imm(5'd6, b);
        emit({boff[12], boff[10:5], 5'd6, 5'd5, f3, boff[4:1], boff[11], OP_BRANCH});
        if (taken)
            skipped_store();
        else
            store_check({name, " fall through"}, F3_W, 5'd5, a, 0);
        store_check({name, " target"}, F3_W, 5'd6, b, 0);
    endtask

    task automatic build_program();
        word_t       a, b, r, q;
        logic [20:0] joff;
        store_check("sp after sweep", F3_W, SP_IDX, RESET_SP, 0);   // first store
        repeat (2)
        begin
            a = $urandom();
            b = $urandom();
            r = {{20{b[11]}}, b[11:0]};                // 12-bit immediate, sign extended
            alu_case("add",   1, F3_ADD,  0, a, b, a + b);
            alu_case("sub",   1, F3_ADD,  1, a, b, a - b);
            alu_case("slt",   1, F3_SLT,  0, a, b, word_t'($signed(a) < $signed(b)));
            alu_case("sltu",  1, F3_SLTU, 0, a, b, word_t'(a < b));
            alu_case("xor",   1, F3_XOR,  0, a, b, a ^ b);
            alu_case("or",    1, F3_OR,   0, a, b, a | b);
            alu_case("and",   1, F3_AND,  0, a, b, a & b);
            alu_case("sll",   1, F3_SLL,  0, a, b, a << b[4:0]);
            alu_case("srl",   1, F3_SR,   0, a, b, a >> b[4:0]);
            alu_case("sra",   1, F3_SR,   1, a, b, word_t'($signed(a) >>> b[4:0]));
            alu_case("addi",  0, F3_ADD,  0, a, r, a + r);
            alu_case("slti",  0, F3_SLT,  0, a, r, word_t'($signed(a) < $signed(r)));
            alu_case("sltiu", 0, F3_SLTU, 0, a, r, word_t'(a < r));
            alu_case("xori",  0, F3_XOR,  0, a, r, a ^ r);
            alu_case("ori",   0, F3_OR,   0, a, r, a | r);
            alu_case("andi",  0, F3_AND,  0, a, r, a & r);
            alu_case("slli",  0, F3_SLL,  0, a, {27'd0, b[4:0]}, a << b[4:0]);
            alu_case("srli",  0, F3_SR,   0, a, {27'd0, b[4:0]}, a >> b[4:0]);
            alu_case("srai",  0, F3_SR,   0, a, {21'd0, 1'b1, 5'd0, b[4:0]},
                     word_t'($signed(a) >>> b[4:0]));   // bit 10 of imm selects arithmetic
        end
        r = $urandom();
        load_imm(5'd8, r);
        for (int off = 0; off < 4; off++)
            store_check($sformatf("sb off %0d", off), F3_B, 5'd8, r, off);
        store_check("sh off 0", F3_H, 5'd8, r, 0);
        store_check("sh off 2", F3_H, 5'd8, r, 2);
        for (int j = 0; j < 2; j++)
            for (int off = 0; off < 4; off++)
            begin
                load_case(F3_B, j, off);
                load_case(F3_BU, j, off);
                if (off % 2 == 0)
                begin
                    load_case(F3_H, j, off);
                    load_case(F3_HU, j, off);
                end
                if (off == 0)
                    load_case(F3_W, j, off);
            end
        a = 32'hFFFF_FFFB;                             // -5, large when unsigned
        b = 32'd3;
        branch_case("beq taken",  F3_BEQ,  r, r, 1);
        branch_case("beq not",    F3_BEQ,  a, b, 0);
        branch_case("bne taken",  F3_BNE,  a, b, 1);
        branch_case("bne not",    F3_BNE,  r, r, 0);
        branch_case("blt taken",  F3_BLT,  a, b, 1);
        branch_case("blt not",    F3_BLT,  b, a, 0);
        branch_case("bge taken",  F3_BGE,  b, a, 1);
        branch_case("bge not",    F3_BGE,  a, b, 0);
        branch_case("bltu taken", F3_BLTU, b, a, 1);
        branch_case("bltu not",   F3_BLTU, a, b, 0);
        branch_case("bgeu taken", F3_BGEU, a, b, 1);
        branch_case("bgeu not",   F3_BGEU, b, a, 0);
        q    = RESET_PC + 4*prog_len;
        joff = 21'd8;
        emit({joff[20], joff[10:1], joff[11], joff[19:12], 5'd10, OP_JAL});
        skipped_store();
        store_check("jal link", F3_W, 5'd10, q + 4, 0);
        q = RESET_PC + 4*(prog_len + 2);               // jalr follows the two word load
        load_imm(5'd11, q + 6);
        emit(enc_i(12'd3, 5'd11, 3'd0, 5'd12, OP_JALR));  // q+9, bit 0 dropped
        skipped_store();
        store_check("jalr link", F3_W, 5'd12, q + 4, 0);
        r = $urandom();
        emit({r[19:0], 5'd13, OP_LUI});
        store_check("lui", F3_W, 5'd13, {r[19:0], 12'h000}, 0);
        q = RESET_PC + 4*prog_len;
        emit({r[31:12], 5'd14, OP_AUIPC});
        store_check("auipc", F3_W, 5'd14, q + {r[31:12], 12'h000}, 0);
        store_check("final x0", F3_W, 5'd0, 32'd0, 0);
        emit({25'd0, OP_JAL});                         // jal x0,0 parks the core
    endtask

    initial
    begin
        void'($urandom(62));
        rst_n     = 1'b0;
        hlt       = 1'b0;
        idata     = '0;
        prog_len  = 0;
        exp_cnt   = 0;
        seen_cnt  = 0;
        foreach (imem[i])
            imem[i] = '0;
        foreach (dmem[i])
            dmem[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
        dmem[LD_BASE/4]     = LD_WORDS[0];
        dmem[LD_BASE/4 + 1] = LD_WORDS[1];
        build_program();
        repeat (RST_CYC) @(posedge CLK);
        #2 rst_n = 1'b1;
        wait (seen_cnt >= 20);                         // well inside the program
        @(posedge CLK);
        #2;
        while (!wr)                                    // halt lands on a store in execute
        begin
            @(posedge CLK);
            #2;
        end
        hlt = 1'b1;
        repeat (4) @(posedge CLK);
        #2 hlt = 1'b0;
        wait (seen_cnt == exp_cnt);
        repeat (2) @(posedge CLK);
        $display("=== PASS ===");
        $finish;
    end

    // watchdog sized from the built program
    initial
    begin
        #1;
        repeat (RST_CYC + NUM_REGS + 4*prog_len + 32) @(posedge CLK);
        fail_run("timeout, the program never reached its final store");
    end

endmodule
